// ==== Makefile ====
TOP   := exu_tb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/exu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_asserts (
    input wire clk,
    input wire rst,
    input wire i_wb_vld,
    input wire i_wb_wen,
    input wire i_wb_except,
    input wire i_eret_vld,
    input wire i_alu_vld,
    input wire i_mul_vld,
    input wire i_alu_stall,
    input wire i_mul_stall,
    input wire i_csr_we
);
    int unsigned fail_cnt = 0;

    // bus quiet once reset has been seen
    a_reset_quiet: assert property (@(posedge clk) rst |=> !i_wb_vld && !i_eret_vld && !i_csr_we)
        else begin
            $error("writeback, return or csr write active right after reset");
            fail_cnt++;
        end

    // a stalled record stays valid into the next cycle
    a_alu_stall_vld: assert property (@(posedge clk) disable iff (rst) i_alu_stall |=> i_alu_vld)
        else begin
            $error("alu dropped its record while stalled");
            fail_cnt++;
        end

    a_mul_stall_vld: assert property (@(posedge clk) disable iff (rst) i_mul_stall |=> i_mul_vld)
        else begin
            $error("mul dropped its record while stalled");
            fail_cnt++;
        end

    // the loser of a collision wins the next cycle
    a_alu_no_double: assert property (@(posedge clk) disable iff (rst) i_alu_stall |=> !i_alu_stall)
        else begin
            $error("alu stalled two cycles in a row");
            fail_cnt++;
        end

    a_mul_no_double: assert property (@(posedge clk) disable iff (rst) i_mul_stall |=> !i_mul_stall)
        else begin
            $error("mul stalled two cycles in a row");
            fail_cnt++;
        end

    a_except_no_wen: assert property (@(posedge clk) disable iff (rst)
                                      i_wb_vld && i_wb_except |-> !i_wb_wen)
        else begin
            $error("exception record with register write enabled");
            fail_cnt++;
        end

    a_csr_we_clean: assert property (@(posedge clk) disable iff (rst) i_csr_we |-> !i_wb_except)
        else begin
            $error("csr write together with an exception");
            fail_cnt++;
        end

endmodule

bind exu_top exu_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .i_wb_vld(o_wb_vld),
    .i_wb_wen(o_wb_wen),
    .i_wb_except(o_wb_except),
    .i_eret_vld(o_eret_vld),
    .i_alu_vld(alu_wb.vld),
    .i_mul_vld(mul_wb.vld),
    .i_alu_stall(alu_stall),
    .i_mul_stall(mul_stall),
    .i_csr_we(csr_we)
);

`default_nettype wire

// ==== tb/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb import exu_pkg::*; ();
    localparam int PERIOD_NS  = 4;
    localparam int N_RAND     = 200;
    localparam int N_MIX      = 200;
    localparam int N_SYS      = 24 + 2 + 3 * 7 + 5;
    localparam int CYCLES     = 8 + 2 * N_RAND + 4 * N_MIX + 8 * N_SYS + 50;
    localparam int TIMEOUT_NS = 2 * CYCLES * PERIOD_NS;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [REG_W-1:0] rd;
        logic             wen;
        logic [XLEN-1:0]  data;
        logic             except;
        logic [3:0]       cause;
        logic             eret;
        logic [XLEN-1:0]  pc;
    } rec_t;

    logic clk;
    logic rst;
    logic i_alu_vld, i_mul_vld;
    op_t i_alu_op;
    logic [XLEN-1:0] i_alu_src0, i_alu_src1, i_mul_src0, i_mul_src1;
    logic [4:0] i_alu_zimm;
    logic [REG_W-1:0] i_alu_rd, i_mul_rd;
    logic [TAG_W-1:0] i_alu_tag, i_mul_tag;
    csr_idx_t i_alu_csr_idx;
    logic o_alu_ready, o_mul_ready, o_wb_vld, o_wb_wen, o_wb_except, o_eret_vld;
    logic [TAG_W-1:0] o_wb_tag;
    logic [REG_W-1:0] o_wb_rd;
    logic [XLEN-1:0] o_wb_data, o_eret_pc;
    cause_t o_wb_cause;
    mode_t o_mode;

    rec_t aq[$];
    rec_t mq[$];
    int checks = 0;
    int errors = 0;
    logic [31:0] seed = 32'd92447;
    logic [4:0] alu_cnt = 5'd0;
    logic [4:0] mul_cnt = 5'd0;
    // model state: sscratch, sepc, mscratch, mepc
    logic [XLEN-1:0] m_csr[4];
    mode_t m_mode = MODE_M;
    op_t csr_ops[6] = '{OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    csr_idx_t scratch[2] = '{CSR_MSCRATCH, CSR_SSCRATCH};

    tb_clkgen #(.PERIOD_NS(PERIOD_NS)) u_clkgen (.o_clk(clk));

    exu_top dut0 (
        .clk(clk), .rst(rst),
        .i_alu_vld(i_alu_vld), .i_alu_op(i_alu_op), .i_alu_src0(i_alu_src0),
        .i_alu_src1(i_alu_src1), .i_alu_zimm(i_alu_zimm), .i_alu_rd(i_alu_rd),
        .i_alu_tag(i_alu_tag), .i_alu_csr_idx(i_alu_csr_idx),
        .i_mul_vld(i_mul_vld), .i_mul_src0(i_mul_src0), .i_mul_src1(i_mul_src1),
        .i_mul_rd(i_mul_rd), .i_mul_tag(i_mul_tag),
        .o_alu_ready(o_alu_ready), .o_mul_ready(o_mul_ready),
        .o_wb_vld(o_wb_vld), .o_wb_tag(o_wb_tag), .o_wb_rd(o_wb_rd), .o_wb_wen(o_wb_wen),
        .o_wb_data(o_wb_data), .o_wb_except(o_wb_except), .o_wb_cause(o_wb_cause),
        .o_eret_vld(o_eret_vld), .o_eret_pc(o_eret_pc), .o_mode(o_mode)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    function automatic logic [63:0] alu_ref(input op_t op, input logic [63:0] a, b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[5:0];
            OP_SRL:  return a >> b[5:0];
            OP_SRA:  return 64'($signed(a) >>> b[5:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU: return (a < b) ? 64'd1 : 64'd0;
            default: return 64'd0;
        endcase
    endfunction

    function automatic int csr_slot(input csr_idx_t idx);
        case (idx)
            CSR_SSCRATCH: return 0;
            CSR_SEPC:     return 1;
            CSR_MSCRATCH: return 2;
            CSR_MEPC:     return 3;
            default:      return -1;
        endcase
    endfunction

    // expected record of a system op, model state moves along with it
    task automatic sys_model(input op_t op, input csr_idx_t idx, input logic [63:0] src,
                             input logic [4:0] zimm, output rec_t r);
        int k;
        logic [63:0] opnd;
        r = '0;
        k = csr_slot(idx);
        opnd = (op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) ? 64'(zimm) : src;
        r.except = 1'b1;
        r.cause = 4'd2;
        if (op == OP_ECALL) begin
            r.cause = 4'd8 + {2'b00, m_mode};
        end else if (op == OP_EBREAK) begin
            r.cause = 4'd3;
        end else if (op == OP_MRET && m_mode == MODE_M) begin
            r = '0;
            r.eret = 1'b1;
            r.pc = m_csr[3];
            m_mode = MODE_S;
        end else if (op == OP_SRET && m_mode != MODE_U) begin
            r = '0;
            r.eret = 1'b1;
            r.pc = m_csr[1];
            m_mode = MODE_U;
        end else if (op != OP_MRET && op != OP_SRET && k >= 0 && idx[9:8] <= m_mode) begin
            r = '0;
            r.wen = 1'b1;
            r.data = m_csr[k];
            if (op == OP_CSRRW || op == OP_CSRRWI) begin
                m_csr[k] = opnd;
            end else if (op == OP_CSRRS || op == OP_CSRRSI) begin
                m_csr[k] = m_csr[k] | opnd;
            end else begin
                m_csr[k] = m_csr[k] & ~opnd;
            end
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic issue_alu(input op_t op, input logic [63:0] a, b, input logic [4:0] zimm,
                             input csr_idx_t idx);
        rec_t r;
        logic [31:0] rv;
        if (is_sys_op(op)) begin
            sys_model(op, idx, a, zimm, r);
        end else begin
            r = '0;
            r.wen = 1'b1;
            r.data = alu_ref(op, a, b);
        end
        rv = next_rand();
        r.tag = {1'b0, alu_cnt};
        r.rd = rv[5:0];
        alu_cnt = alu_cnt + 5'd1;
        i_alu_vld = 1'b1;
        i_alu_op = op;
        i_alu_src0 = a;
        i_alu_src1 = b;
        i_alu_zimm = zimm;
        i_alu_csr_idx = idx;
        i_alu_tag = r.tag;
        i_alu_rd = r.rd;
        while (!o_alu_ready) @(negedge clk);
        aq.push_back(r);
        @(negedge clk);
        i_alu_vld = 1'b0;
    endtask

    task automatic issue_mul(input logic [63:0] a, b);
        rec_t r;
        logic [31:0] rv;
        rv = next_rand();
        r = '0;
        r.wen = 1'b1;
        r.data = a * b;
        r.tag = {1'b1, mul_cnt};
        r.rd = rv[5:0];
        mul_cnt = mul_cnt + 5'd1;
        i_mul_vld = 1'b1;
        i_mul_src0 = a;
        i_mul_src1 = b;
        i_mul_tag = r.tag;
        i_mul_rd = r.rd;
        while (!o_mul_ready) @(negedge clk);
        mq.push_back(r);
        @(negedge clk);
        i_mul_vld = 1'b0;
    endtask

    // one extra edge so csr and mode updates land before the next issue
    task automatic wait_idle();
        while (aq.size() != 0 || mq.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic sys_op(input op_t op, input csr_idx_t idx, input logic [63:0] src,
                          input logic [4:0] zimm);
        issue_alu(op, src, 64'd0, zimm, idx);
        wait_idle();
        check_val("o_mode", 64'(m_mode), 64'(o_mode));
    endtask

    task automatic exc_round();
        logic [31:0] rv;
        rv = next_rand();
        sys_op(OP_ECALL, 12'h000, 64'd0, 5'd0);
        sys_op(OP_EBREAK, 12'h000, 64'd0, 5'd0);
        sys_op(OP_CSRRW, 12'h7c0, rand64(), 5'd0);
        sys_op(OP_CSRRW, CSR_MSCRATCH, rand64(), 5'd0);
        sys_op(OP_CSRRSI, CSR_SSCRATCH, 64'd0, rv[4:0]);
        sys_op(OP_CSRRS, CSR_MSCRATCH, 64'd0, 5'd0);
        sys_op(OP_CSRRS, CSR_SSCRATCH, 64'd0, 5'd0);
    endtask

    task automatic check_wb();
        rec_t r;
        logic hit;
        r = '0;
        hit = 1'b0;
        if (o_wb_vld) begin
            if (aq.size() > 0 && aq[0].tag == o_wb_tag) begin
                r = aq.pop_front();
                hit = 1'b1;
            end else if (mq.size() > 0 && mq[0].tag == o_wb_tag) begin
                r = mq.pop_front();
                hit = 1'b1;
            end else begin
                errors++;
                $display("%0t ns: writeback tag %0d matches no pending instruction",
                         $time, o_wb_tag);
            end
        end
        if (hit) begin
            check_val("o_wb_rd", 64'(r.rd), 64'(o_wb_rd));
            check_val("o_wb_wen", 64'(r.wen), 64'(o_wb_wen));
            check_val("o_wb_except", 64'(r.except), 64'(o_wb_except));
            if (r.wen) begin
                check_val("o_wb_data", r.data, o_wb_data);
            end
            if (r.except) begin
                check_val("o_wb_cause", 64'(r.cause), 64'(o_wb_cause));
            end
            if (r.eret) begin
                check_val("o_eret_pc", r.pc, o_eret_pc);
            end
        end
        check_val("o_eret_vld", 64'(r.eret), 64'(o_eret_vld));
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_wb();
        end
    end

    initial begin : watchdog
        #TIMEOUT_NS;
        $display("timeout after %0d ns, writeback never drained", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] rv;
        for (int i = 0; i < 4; i++) begin
            m_csr[i] = 64'd0;
        end
        rst = 1'b1;
        i_alu_vld = 1'b0;
        i_alu_op = OP_ADD;
        i_alu_src0 = '0;
        i_alu_src1 = '0;
        i_alu_zimm = '0;
        i_alu_rd = '0;
        i_alu_tag = '0;
        i_alu_csr_idx = '0;
        i_mul_vld = 1'b0;
        i_mul_src0 = '0;
        i_mul_src1 = '0;
        i_mul_rd = '0;
        i_mul_tag = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_val("o_alu_ready", 64'd1, 64'(o_alu_ready));
        check_val("o_mul_ready", 64'd1, 64'(o_mul_ready));
        check_val("o_mode", 64'(MODE_M), 64'(o_mode));

        repeat (N_RAND) begin
            issue_alu(op_t'(5'(next_rand() % 32'd10)), rand64(), rand64(), 5'd0, 12'h000);
        end
        wait_idle();

        // both units issue every cycle so the bus collides
        fork
            repeat (N_MIX) begin
                issue_alu(op_t'(5'(next_rand() % 32'd10)), rand64(), rand64(), 5'd0, 12'h000);
            end
            repeat (N_MIX) begin
                issue_mul(rand64(), rand64());
            end
        join
        wait_idle();

        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 6; i++) begin
                rv = next_rand();
                sys_op(csr_ops[i], scratch[k], rand64(), rv[4:0]);
                sys_op(OP_CSRRS, scratch[k], 64'd0, 5'd0);
            end
        end
        sys_op(OP_CSRRW, CSR_MEPC, rand64(), 5'd0);
        sys_op(OP_CSRRW, CSR_SEPC, rand64(), 5'd0);

        // M, then S after mret, then U after sret
        exc_round();
        sys_op(OP_MRET, 12'h000, 64'd0, 5'd0);
        exc_round();
        sys_op(OP_MRET, 12'h000, 64'd0, 5'd0);
        sys_op(OP_SRET, 12'h000, 64'd0, 5'd0);
        exc_round();
        sys_op(OP_SRET, 12'h000, 64'd0, 5'd0);
        sys_op(OP_MRET, 12'h000, 64'd0, 5'd0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.u_asserts.fail_cnt);
        if (errors == 0 && dut0.u_asserts.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);
    initial o_clk = 1'b0;

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/exu_pkg.sv
verilog/exu_ifs.sv
verilog/alu_scu.sv
verilog/mul_unit.sv
verilog/csr_regfile.sv
verilog/wb_arbiter.sv
verilog/exu_top.sv
tb/tb_clkgen.sv
tb/exu_asserts.sv
tb/exu_tb.sv

// ==== verilog/alu_scu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_scu import exu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_vld,
    input  wire op_t         i_op,
    input  wire [XLEN-1:0]   i_src0,
    input  wire [XLEN-1:0]   i_src1,
    input  wire [4:0]        i_zimm,
    input  wire [REG_W-1:0]  i_rd,
    input  wire [TAG_W-1:0]  i_tag,
    input  wire csr_idx_t    i_csr_idx,
    input  wire              i_wb_stall,
    input  wire [XLEN-1:0]   i_csr_rdata,
    input  wire              i_csr_illegal,
    input  wire mode_t       i_mode,
    input  wire [XLEN-1:0]   i_mepc,
    input  wire [XLEN-1:0]   i_sepc,
    output logic             o_ready,
    output csr_idx_t         o_csr_ridx,
    output logic             o_csr_we,
    output csr_idx_t         o_csr_widx,
    output logic [XLEN-1:0]  o_csr_wdata,
    wb_if.producer           wb,
    eret_if.src              eret
);
    logic             s1_vld;
    op_t              s1_op;
    logic [XLEN-1:0]  s1_src0;
    logic [XLEN-1:0]  s1_src1;
    logic [4:0]       s1_zimm;
    logic [REG_W-1:0] s1_rd;
    logic [TAG_W-1:0] s1_tag;
    csr_idx_t         s1_csr_idx;
    logic [XLEN-1:0]  s1_csr_rdata;
    logic             s1_csr_illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (!i_wb_stall) begin
            s1_vld <= i_vld;
        end
    end

    // csr value is sampled at issue
    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            s1_op          <= i_op;
            s1_src0        <= i_src0;
            s1_src1        <= i_src1;
            s1_zimm        <= i_zimm;
            s1_rd          <= i_rd;
            s1_tag         <= i_tag;
            s1_csr_idx     <= i_csr_idx;
            s1_csr_rdata   <= i_csr_rdata;
            s1_csr_illegal <= i_csr_illegal;
        end
    end

    logic [XLEN-1:0] alu_res;

    always_comb begin
        case (s1_op)
            OP_ADD:  alu_res = s1_src0 + s1_src1;
            OP_SUB:  alu_res = s1_src0 - s1_src1;
            OP_AND:  alu_res = s1_src0 & s1_src1;
            OP_OR:   alu_res = s1_src0 | s1_src1;
            OP_XOR:  alu_res = s1_src0 ^ s1_src1;
            OP_SLL:  alu_res = s1_src0 << s1_src1[5:0];
            OP_SRL:  alu_res = s1_src0 >> s1_src1[5:0];
            OP_SRA:  alu_res = $signed(s1_src0) >>> s1_src1[5:0];
            OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(s1_src0) < $signed(s1_src1)};
            OP_SLTU: alu_res = {{(XLEN-1){1'b0}}, s1_src0 < s1_src1};
            default: alu_res = '0;
        endcase
    end

    logic            is_csr;
    logic            use_zimm;
    logic [XLEN-1:0] csr_opnd;
    logic [XLEN-1:0] csr_new;

    assign is_csr   = (s1_op >= OP_CSRRW) && (s1_op <= OP_CSRRSI);
    assign use_zimm = (s1_op > OP_CSRRS) && (s1_op <= OP_CSRRSI);
    assign csr_opnd = use_zimm ? {{(XLEN-5){1'b0}}, s1_zimm} : s1_src0;

    always_comb begin
        case (s1_op)
            OP_CSRRW, OP_CSRRWI: csr_new = csr_opnd;
            OP_CSRRC, OP_CSRRCI: csr_new = s1_csr_rdata & ~csr_opnd;
            OP_CSRRS, OP_CSRRSI: csr_new = s1_csr_rdata | csr_opnd;
            default:             csr_new = s1_csr_rdata;
        endcase
    end

    logic   is_ecall;
    logic   is_ebreak;
    logic   is_mret;
    logic   is_sret;
    logic   illegal;
    logic   exc;
    logic   csr_wr;
    logic   wen;
    cause_t cause;

    assign is_ecall  = (s1_op == OP_ECALL);
    assign is_ebreak = (s1_op == OP_EBREAK);
    assign is_mret   = (s1_op == OP_MRET);
    assign is_sret   = (s1_op == OP_SRET);

    // returns need at least their own mode
    assign illegal = (is_csr && s1_csr_illegal) ||
                     (is_mret && (i_mode < MODE_M)) ||
                     (is_sret && (i_mode < MODE_S));
    assign exc     = illegal || is_ecall || is_ebreak;

    assign cause = illegal  ? CAUSE_ILLEGAL :
                   is_ecall ? cause_t'(4'd8 + {2'b00, i_mode}) :
                   CAUSE_BREAK;

    // set/clear with a zero operand leaves the csr alone
    assign csr_wr = is_csr && !exc &&
                    ((s1_op == OP_CSRRW) || (s1_op == OP_CSRRWI) || (csr_opnd != '0));
    assign wen    = !exc && (!is_sys_op(s1_op) || is_csr);

    logic            csr_we_q;
    logic            mret_q;
    logic            sret_q;
    logic [XLEN-1:0] npc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.vld    <= 1'b0;
            wb.except <= 1'b0;
            csr_we_q  <= 1'b0;
            mret_q    <= 1'b0;
            sret_q    <= 1'b0;
        end else if (!i_wb_stall) begin
            wb.vld    <= s1_vld;
            wb.except <= s1_vld && exc;
            csr_we_q  <= s1_vld && csr_wr;
            mret_q    <= s1_vld && is_mret && !illegal;
            sret_q    <= s1_vld && is_sret && !illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            wb.tag      <= s1_tag;
            wb.rd       <= s1_rd;
            wb.wen      <= wen;
            wb.data     <= is_csr ? s1_csr_rdata : is_sys_op(s1_op) ? '0 : alu_res;
            wb.cause    <= cause;
            o_csr_widx  <= s1_csr_idx;
            o_csr_wdata <= csr_new;
            npc_q       <= is_mret ? i_mepc : i_sepc;
        end
    end

    assign o_ready    = !i_wb_stall;
    assign o_csr_ridx = i_csr_idx;

    // side effects only in the cycle the record wins the bus
    assign o_csr_we  = csr_we_q && !i_wb_stall;
    assign eret.mret = mret_q && !i_wb_stall;
    assign eret.sret = sret_q && !i_wb_stall;
    assign eret.npc  = npc_q;
    assign eret.tag  = wb.tag;

endmodule

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile import exu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire csr_idx_t    i_ridx,
    input  wire              i_we,
    input  wire csr_idx_t    i_widx,
    input  wire [XLEN-1:0]   i_wdata,
    output logic [XLEN-1:0]  o_rdata,
    output logic             o_illegal,
    output mode_t            o_mode,
    output logic [XLEN-1:0]  o_mepc,
    output logic [XLEN-1:0]  o_sepc,
    eret_if.dst              eret
);
    mode_t           mode;
    logic [XLEN-1:0] sscratch;
    logic [XLEN-1:0] sepc;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic            known;

    always_comb begin
        known   = 1'b1;
        o_rdata = '0;
        case (i_ridx)
            CSR_SSCRATCH: o_rdata = sscratch;
            CSR_SEPC:     o_rdata = sepc;
            CSR_MSCRATCH: o_rdata = mscratch;
            CSR_MEPC:     o_rdata = mepc;
            default:      known = 1'b0;
        endcase
    end

    // privilege field above current mode is illegal
    assign o_illegal = !known || (i_ridx[9:8] > mode);

    always_ff @(posedge clk) begin
        if (rst) begin
            mode     <= MODE_M;
            sscratch <= '0;
            sepc     <= '0;
            mscratch <= '0;
            mepc     <= '0;
        end else begin
            // simplified previous-privilege: mret to S, sret to U
            if (eret.mret) begin
                mode <= MODE_S;
            end else if (eret.sret) begin
                mode <= MODE_U;
            end
            if (i_we) begin
                case (i_widx)
                    CSR_SSCRATCH: sscratch <= i_wdata;
                    CSR_SEPC:     sepc     <= i_wdata;
                    CSR_MSCRATCH: mscratch <= i_wdata;
                    CSR_MEPC:     mepc     <= i_wdata;
                    default: ;
                endcase
            end
        end
    end

    assign o_mode = mode;
    assign o_mepc = mepc;
    assign o_sepc = sepc;

endmodule

`default_nettype wire

// ==== verilog/exu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// one unit's writeback record
interface wb_if import exu_pkg::*; ();
    logic             vld;
    logic [TAG_W-1:0] tag;
    logic [REG_W-1:0] rd;
    logic             wen;
    logic [XLEN-1:0]  data;
    logic             except;
    cause_t           cause;

    modport producer (
        output vld, tag, rd, wen, data, except, cause
    );

    modport consumer (
        input vld, tag, rd, wen, data, except, cause
    );
endinterface

// mret/sret from the scu to the csr file
interface eret_if import exu_pkg::*; ();
    logic             mret;
    logic             sret;
    logic [XLEN-1:0]  npc;
    logic [TAG_W-1:0] tag;

    modport src (
        output mret, sret, npc, tag
    );

    modport dst (
        input mret, sret, npc, tag
    );
endinterface

`default_nettype wire

// ==== verilog/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    localparam int XLEN  = 64;
    localparam int TAG_W = 6;
    localparam int REG_W = 6;

    // register forms first, csrrs last of them so that op > csrrs picks zimm
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_CSRRW,
        OP_CSRRC,
        OP_CSRRS,
        OP_CSRRWI,
        OP_CSRRCI,
        OP_CSRRSI,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET,
        OP_SRET
    } op_t;

    typedef enum logic [1:0] {
        MODE_U = 2'd0,
        MODE_S = 2'd1,
        MODE_M = 2'd3
    } mode_t;

    // ecall cause is 8 plus the current mode
    typedef enum logic [3:0] {
        CAUSE_ILLEGAL = 4'd2,
        CAUSE_BREAK   = 4'd3,
        CAUSE_ECALL_U = 4'd8,
        CAUSE_ECALL_S = 4'd9,
        CAUSE_ECALL_M = 4'd11
    } cause_t;

    // bits 9:8 hold the lowest mode allowed to access
    typedef logic [11:0] csr_idx_t;

    localparam csr_idx_t CSR_SSCRATCH = 12'h140;
    localparam csr_idx_t CSR_SEPC     = 12'h141;
    localparam csr_idx_t CSR_MSCRATCH = 12'h340;
    localparam csr_idx_t CSR_MEPC     = 12'h341;

    // everything from csrrw on goes to the system side
    function automatic logic is_sys_op(input op_t op);
        return op >= OP_CSRRW;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_alu_vld,
    input  wire op_t         i_alu_op,
    input  wire [XLEN-1:0]   i_alu_src0,
    input  wire [XLEN-1:0]   i_alu_src1,
    input  wire [4:0]        i_alu_zimm,
    input  wire [REG_W-1:0]  i_alu_rd,
    input  wire [TAG_W-1:0]  i_alu_tag,
    input  wire csr_idx_t    i_alu_csr_idx,
    input  wire              i_mul_vld,
    input  wire [XLEN-1:0]   i_mul_src0,
    input  wire [XLEN-1:0]   i_mul_src1,
    input  wire [REG_W-1:0]  i_mul_rd,
    input  wire [TAG_W-1:0]  i_mul_tag,
    output logic             o_alu_ready,
    output logic             o_mul_ready,
    output logic             o_wb_vld,
    output logic [TAG_W-1:0] o_wb_tag,
    output logic [REG_W-1:0] o_wb_rd,
    output logic             o_wb_wen,
    output logic [XLEN-1:0]  o_wb_data,
    output logic             o_wb_except,
    output cause_t           o_wb_cause,
    output logic             o_eret_vld,
    output logic [XLEN-1:0]  o_eret_pc,
    output mode_t            o_mode
);
    wb_if   alu_wb ();
    wb_if   mul_wb ();
    eret_if eret ();

    logic            alu_stall;
    logic            mul_stall;
    csr_idx_t        csr_ridx;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_illegal;
    logic            csr_we;
    csr_idx_t        csr_widx;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] sepc;

    alu_scu u_alu_scu (
        .clk(clk), .rst(rst),
        .i_vld(i_alu_vld), .i_op(i_alu_op), .i_src0(i_alu_src0), .i_src1(i_alu_src1),
        .i_zimm(i_alu_zimm), .i_rd(i_alu_rd), .i_tag(i_alu_tag), .i_csr_idx(i_alu_csr_idx),
        .i_wb_stall(alu_stall), .i_csr_rdata(csr_rdata), .i_csr_illegal(csr_illegal),
        .i_mode(o_mode), .i_mepc(mepc), .i_sepc(sepc),
        .o_ready(o_alu_ready), .o_csr_ridx(csr_ridx), .o_csr_we(csr_we),
        .o_csr_widx(csr_widx), .o_csr_wdata(csr_wdata),
        .wb(alu_wb.producer), .eret(eret.src)
    );

    mul_unit u_mul_unit (
        .clk(clk), .rst(rst),
        .i_vld(i_mul_vld), .i_src0(i_mul_src0), .i_src1(i_mul_src1),
        .i_rd(i_mul_rd), .i_tag(i_mul_tag), .i_wb_stall(mul_stall),
        .o_ready(o_mul_ready), .wb(mul_wb.producer)
    );

    csr_regfile u_csr_regfile (
        .clk(clk), .rst(rst),
        .i_ridx(csr_ridx), .i_we(csr_we), .i_widx(csr_widx), .i_wdata(csr_wdata),
        .o_rdata(csr_rdata), .o_illegal(csr_illegal), .o_mode(o_mode),
        .o_mepc(mepc), .o_sepc(sepc), .eret(eret.dst)
    );

    wb_arbiter u_wb_arbiter (
        .clk(clk), .rst(rst),
        .a(alu_wb.consumer), .b(mul_wb.consumer),
        .o_stall_a(alu_stall), .o_stall_b(mul_stall),
        .o_vld(o_wb_vld), .o_tag(o_wb_tag), .o_rd(o_wb_rd), .o_wen(o_wb_wen),
        .o_data(o_wb_data), .o_except(o_wb_except), .o_cause(o_wb_cause)
    );

    assign o_eret_vld = eret.mret || eret.sret;
    assign o_eret_pc  = eret.npc;

endmodule

`default_nettype wire

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit import exu_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             i_vld,
    input  wire [XLEN-1:0]  i_src0,
    input  wire [XLEN-1:0]  i_src1,
    input  wire [REG_W-1:0] i_rd,
    input  wire [TAG_W-1:0] i_tag,
    input  wire             i_wb_stall,
    output logic            o_ready,
    wb_if.producer          wb
);
    logic             s1_vld;
    logic [XLEN-1:0]  s1_src0;
    logic [XLEN-1:0]  s1_src1;
    logic [REG_W-1:0] s1_rd;
    logic [TAG_W-1:0] s1_tag;
    logic [XLEN-1:0]  prod_lo;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
            wb.vld <= 1'b0;
        end else if (!i_wb_stall) begin
            s1_vld <= i_vld;
            wb.vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            s1_src0 <= i_src0;
            s1_src1 <= i_src1;
            s1_rd   <= i_rd;
            s1_tag  <= i_tag;
            wb.data <= prod_lo;
            wb.rd   <= s1_rd;
            wb.tag  <= s1_tag;
        end
    end

    // low half only, upper bits drop out of the assignment
    assign prod_lo = s1_src0 * s1_src1;

    assign o_ready   = !i_wb_stall;
    assign wb.wen    = 1'b1;
    assign wb.except = 1'b0;
    assign wb.cause  = CAUSE_ILLEGAL;

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import exu_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    wb_if.consumer           a,
    wb_if.consumer           b,
    output logic             o_stall_a,
    output logic             o_stall_b,
    output logic             o_vld,
    output logic [TAG_W-1:0] o_tag,
    output logic [REG_W-1:0] o_rd,
    output logic             o_wen,
    output logic [XLEN-1:0]  o_data,
    output logic             o_except,
    output cause_t           o_cause
);
    // high when b has priority on the next collision
    logic prio_b;
    logic grant_a;

    assign grant_a = a.vld && (!b.vld || !prio_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_b <= 1'b0;
        end else if (a.vld || b.vld) begin
            prio_b <= grant_a;
        end
    end

    assign o_stall_a = a.vld && !grant_a;
    assign o_stall_b = b.vld && grant_a;

    assign o_vld    = a.vld || b.vld;
    assign o_tag    = grant_a ? a.tag    : b.tag;
    assign o_rd     = grant_a ? a.rd     : b.rd;
    assign o_wen    = grant_a ? a.wen    : b.wen;
    assign o_data   = grant_a ? a.data   : b.data;
    assign o_except = grant_a ? a.except : b.except;
    assign o_cause  = grant_a ? a.cause  : b.cause;

endmodule

`default_nettype wire
